// File: design/ihex_pkg.sv
// Intel HEX byte, address and count types, record types, error codes, decoder states, payloads.

`default_nettype none

package ihex_pkg;

	// ==============================
	// Field types
	// ==============================

	typedef logic [7:0] ihex_byte_t;
	typedef logic [15:0] ihex_addr_t;
	typedef logic [15:0] record_count_t;

	typedef enum logic [7:0] {
		REC_DATA = 8'h00,
		REC_EOF  = 8'h01
	} ihex_rectype_t;

	typedef enum logic [2:0] {
		ERR_NONE         = 3'd0,
		ERR_BAD_CHAR     = 3'd1,
		ERR_BAD_CHECKSUM = 3'd2,
		ERR_BAD_TYPE     = 3'd3,
		ERR_UNMAPPED     = 3'd4
	} ihex_error_t;

	// Characters outside the hex fields.
	localparam ihex_byte_t CHAR_COLON = 8'h3A;
	localparam ihex_byte_t CHAR_CR = 8'h0D;
	localparam ihex_byte_t CHAR_LF = 8'h0A;

	// ==============================
	// Decoder states
	// ==============================

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SYNC,
		ST_COUNT,
		ST_ADDR,
		ST_TYPE,
		ST_DATA,
		ST_CHECKSUM
	} ihex_state_t;

	// Travels with the write strobe.
	typedef struct packed {
		ihex_addr_t addr;
		ihex_byte_t data;
	} ihex_write_t;

	// Travels with the status strobe. eor is low for an aborted record.
	typedef struct packed {
		ihex_rectype_t rec_type;
		ihex_error_t error;
		logic eor;
	} ihex_status_t;

endpackage

`default_nettype wire

// File: design/ihex_record_decoder.sv
// Intel HEX record decoder: hex pair assembly, field walk, checksum, write and status strobes.

`default_nettype none
`timescale 1ns/1ps

module ihex_record_decoder (
	input wire logic clk,
	input wire logic soft_reset,
	input wire logic i_char_valid,
	input wire ihex_pkg::ihex_byte_t i_char,
	output logic o_wr_valid,
	output ihex_pkg::ihex_write_t o_wr,
	output logic o_rec_valid,
	output ihex_pkg::ihex_status_t o_rec
);

	// Returns {valid, nibble} for one ASCII hex digit.
	function automatic logic [4:0] hex_decode(input ihex_pkg::ihex_byte_t c);
		logic [4:0] r;
		r = 5'd0;
		if (c >= "0" && c <= "9") begin
			r = {1'b1, 4'(c - "0")};
		end else if (c >= "A" && c <= "F") begin
			r = {1'b1, 4'(c - "A" + 8'd10)};
		end else if (c >= "a" && c <= "f") begin
			r = {1'b1, 4'(c - "a" + 8'd10)};
		end
		return r;
	endfunction

	ihex_pkg::ihex_state_t state;
	logic half;
	logic [3:0] hi_nib;
	ihex_pkg::ihex_byte_t sum;
	ihex_pkg::ihex_byte_t rec_len;
	ihex_pkg::ihex_byte_t byte_idx;
	ihex_pkg::ihex_byte_t rec_type;
	ihex_pkg::ihex_addr_t wr_addr;

	logic [4:0] hex;
	logic hex_ok;
	logic is_colon;
	logic is_eol;
	logic type_ok;
	ihex_pkg::ihex_byte_t cur_byte;
	ihex_pkg::ihex_byte_t sum_next;

	assign hex = hex_decode(i_char);
	assign hex_ok = hex[4];
	assign is_colon = i_char == ihex_pkg::CHAR_COLON;
	assign is_eol = (i_char == ihex_pkg::CHAR_CR) || (i_char == ihex_pkg::CHAR_LF);
	assign cur_byte = {hi_nib, hex[3:0]};
	assign sum_next = sum + cur_byte;
	assign type_ok = (rec_type == ihex_pkg::REC_DATA) || (rec_type == ihex_pkg::REC_EOF);

	// ==============================
	// Record field walk
	// ==============================

	always_ff @(posedge clk) begin
		o_wr_valid <= 1'b0;
		o_rec_valid <= 1'b0;
		if (soft_reset) begin
			state <= ihex_pkg::ST_IDLE;
			half <= 1'b0;
		end else if (i_char_valid) begin
			case (state)
			ihex_pkg::ST_IDLE,
			ihex_pkg::ST_SYNC: begin
				if (is_colon) begin
					state <= ihex_pkg::ST_COUNT;
					half <= 1'b0;
					sum <= '0;
				end else if (state == ihex_pkg::ST_IDLE && !is_eol) begin
					// Junk between records.
					o_rec_valid <= 1'b1;
					o_rec.rec_type <= ihex_pkg::ihex_rectype_t'(rec_type);
					o_rec.error <= ihex_pkg::ERR_BAD_CHAR;
					o_rec.eor <= 1'b0;
					state <= ihex_pkg::ST_SYNC;
				end
			end

			default: begin
				if (!hex_ok) begin
					o_rec_valid <= 1'b1;
					o_rec.rec_type <= ihex_pkg::ihex_rectype_t'(rec_type);
					o_rec.error <= ihex_pkg::ERR_BAD_CHAR;
					o_rec.eor <= 1'b0;
					state <= ihex_pkg::ST_SYNC;
				end else if (!half) begin
					hi_nib <= hex[3:0];
					half <= 1'b1;
				end else begin
					half <= 1'b0;
					sum <= sum_next;
					case (state)
					ihex_pkg::ST_COUNT: begin
						rec_len <= cur_byte;
						byte_idx <= '0;
						state <= ihex_pkg::ST_ADDR;
					end

					ihex_pkg::ST_ADDR: begin
						if (byte_idx == '0) begin
							wr_addr[15:8] <= cur_byte;
							byte_idx <= 8'd1;
						end else begin
							wr_addr[7:0] <= cur_byte;
							state <= ihex_pkg::ST_TYPE;
						end
					end

					ihex_pkg::ST_TYPE: begin
						rec_type <= cur_byte;
						byte_idx <= rec_len;
						state <= (rec_len == '0) ? ihex_pkg::ST_CHECKSUM : ihex_pkg::ST_DATA;
					end

					ihex_pkg::ST_DATA: begin
						// Bytes of an unsupported type are dropped.
						o_wr_valid <= rec_type == ihex_pkg::REC_DATA;
						o_wr.addr <= wr_addr;
						o_wr.data <= cur_byte;
						wr_addr <= wr_addr + 16'd1;
						byte_idx <= byte_idx - 8'd1;
						if (byte_idx == 8'd1) begin
							state <= ihex_pkg::ST_CHECKSUM;
						end
					end

					default: begin
						o_rec_valid <= 1'b1;
						o_rec.rec_type <= ihex_pkg::ihex_rectype_t'(rec_type);
						o_rec.eor <= 1'b1;
						if (sum_next != '0) begin
							o_rec.error <= ihex_pkg::ERR_BAD_CHECKSUM;
						end else if (!type_ok) begin
							o_rec.error <= ihex_pkg::ERR_BAD_TYPE;
						end else begin
							o_rec.error <= ihex_pkg::ERR_NONE;
						end
						state <= ihex_pkg::ST_IDLE;
					end
					endcase
				end
			end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/load_sequencer.sv
// Boot sequencer FSM: record count, first error latch and core enable after a clean end of file.

`default_nettype none
`timescale 1ns/1ps

module load_sequencer (
	input wire logic clk,
	input wire logic soft_reset,
	input wire logic i_rec_valid,
	input wire ihex_pkg::ihex_status_t i_rec,
	input wire logic i_wr_unmapped,
	output logic o_loading,
	output logic o_core_en,
	output ihex_pkg::ihex_error_t o_error,
	output ihex_pkg::record_count_t o_record_count
);

	mk14_pkg::seq_state_t state;

	// Loader owns the memory only while waiting for records.
	assign o_loading = state == mk14_pkg::S_RX_WAIT;

	// ==============================
	// Boot FSM
	// ==============================

	always_ff @(posedge clk) begin
		if (soft_reset) begin
			state <= mk14_pkg::S_RX_WAIT;
			o_core_en <= 1'b0;
			o_error <= ihex_pkg::ERR_NONE;
			o_record_count <= '0;
		end else begin
			case (state)
			mk14_pkg::S_RX_WAIT: begin
				if (i_wr_unmapped) begin
					o_error <= ihex_pkg::ERR_UNMAPPED;
					state <= mk14_pkg::S_ERROR;
				end else if (i_rec_valid) begin
					if (i_rec.error != ihex_pkg::ERR_NONE) begin
						o_error <= i_rec.error;
						state <= mk14_pkg::S_ERROR;
					end else if (i_rec.eor) begin
						o_record_count <= o_record_count + 16'd1;
						if (i_rec.rec_type == ihex_pkg::REC_EOF) begin
							state <= mk14_pkg::S_START;
						end
					end
				end
			end

			mk14_pkg::S_START: begin
				o_core_en <= 1'b1;
				state <= mk14_pkg::S_RUNNING;
			end

			// Running and error are left only by soft reset.
			default: begin
				state <= state;
			end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/mk14_loader.sv
// MK14 program loader top: HEX decoder, memory map and boot sequencer.

`default_nettype none
`timescale 1ns/1ps

module mk14_loader (
	input wire logic clk,
	input wire logic soft_reset,
	input wire logic i_rx_valid,
	input wire ihex_pkg::ihex_byte_t i_rx_data,
	input wire logic i_rd_en,
	input wire mk14_pkg::mk14_addr_t i_rd_addr,
	output mk14_pkg::mk14_data_t o_rd_data,
	output logic o_core_en,
	output logic o_loading,
	output ihex_pkg::ihex_error_t o_error,
	output ihex_pkg::record_count_t o_record_count
);

	logic char_valid;
	logic wr_valid;
	ihex_pkg::ihex_write_t wr;
	logic rec_valid;
	ihex_pkg::ihex_status_t rec;
	logic wr_unmapped;

	// Characters are dropped once loading is over.
	assign char_valid = i_rx_valid & o_loading;

	ihex_record_decoder i_ihex_record_decoder (
		.clk,
		.soft_reset,
		.i_char_valid(char_valid),
		.i_char(i_rx_data),
		.o_wr_valid(wr_valid),
		.o_wr(wr),
		.o_rec_valid(rec_valid),
		.o_rec(rec)
	);

	mk14_memory_map i_mk14_memory_map (
		.clk,
		.i_wr_valid(wr_valid),
		.i_wr(wr),
		.o_wr_unmapped(wr_unmapped),
		.i_rd_en,
		.i_rd_addr,
		.o_rd_data
	);

	load_sequencer i_load_sequencer (
		.clk,
		.soft_reset,
		.i_rec_valid(rec_valid),
		.i_rec(rec),
		.i_wr_unmapped(wr_unmapped),
		.o_loading,
		.o_core_en,
		.o_error,
		.o_record_count
	);

endmodule

`default_nettype wire

// File: design/mk14_memory_map.sv
// MK14 memory map: ROM, extended RAM and standard RAM with address decode, write and read ports.

`default_nettype none
`timescale 1ns/1ps

module mk14_memory_map (
	input wire logic clk,
	input wire logic i_wr_valid,
	input wire ihex_pkg::ihex_write_t i_wr,
	output logic o_wr_unmapped,
	input wire logic i_rd_en,
	input wire mk14_pkg::mk14_addr_t i_rd_addr,
	output mk14_pkg::mk14_data_t o_rd_data
);

	function automatic logic in_region(
		input mk14_pkg::mk14_offset_t off,
		input int unsigned base,
		input int unsigned size
	);
		return (32'(off) >= base) && (32'(off) < base + size);
	endfunction

	mk14_pkg::mk14_data_t rom [0:mk14_pkg::ROM_SIZE-1];
	mk14_pkg::mk14_data_t ext_ram [0:mk14_pkg::EXT_RAM_SIZE-1];
	mk14_pkg::mk14_data_t std_ram [0:mk14_pkg::STD_RAM_SIZE-1];

	mk14_pkg::mk14_offset_t wr_off;
	mk14_pkg::mk14_offset_t rd_off;
	logic wr_rom, wr_ext, wr_std;
	logic rd_rom, rd_ext, rd_std;

	// Upper address bits are mirrors.
	assign wr_off = i_wr.addr[mk14_pkg::ADDR_DECODE_BITS-1:0];
	assign rd_off = i_rd_addr[mk14_pkg::ADDR_DECODE_BITS-1:0];

	assign wr_rom = in_region(wr_off, mk14_pkg::ROM_BASE, mk14_pkg::ROM_SIZE);
	assign wr_ext = in_region(wr_off, mk14_pkg::EXT_RAM_BASE, mk14_pkg::EXT_RAM_SIZE);
	assign wr_std = in_region(wr_off, mk14_pkg::STD_RAM_BASE, mk14_pkg::STD_RAM_SIZE);

	assign rd_rom = in_region(rd_off, mk14_pkg::ROM_BASE, mk14_pkg::ROM_SIZE);
	assign rd_ext = in_region(rd_off, mk14_pkg::EXT_RAM_BASE, mk14_pkg::EXT_RAM_SIZE);
	assign rd_std = in_region(rd_off, mk14_pkg::STD_RAM_BASE, mk14_pkg::STD_RAM_SIZE);

	// ==============================
	// Write port
	// ==============================

	// ROM is writable while the loader owns the bus.
	always_ff @(posedge clk) begin
		if (i_wr_valid) begin
			if (wr_rom) begin
				rom[wr_off[mk14_pkg::ROM_INDEX_BITS-1:0]] <= i_wr.data;
			end else if (wr_ext) begin
				ext_ram[wr_off[mk14_pkg::RAM_INDEX_BITS-1:0]] <= i_wr.data;
			end else if (wr_std) begin
				std_ram[wr_off[mk14_pkg::RAM_INDEX_BITS-1:0]] <= i_wr.data;
			end
		end
		o_wr_unmapped <= i_wr_valid && !(wr_rom || wr_ext || wr_std);
	end

	// ==============================
	// Read port
	// ==============================

	always_ff @(posedge clk) begin
		if (i_rd_en) begin
			if (rd_rom) begin
				o_rd_data <= rom[rd_off[mk14_pkg::ROM_INDEX_BITS-1:0]];
			end else if (rd_ext) begin
				o_rd_data <= ext_ram[rd_off[mk14_pkg::RAM_INDEX_BITS-1:0]];
			end else if (rd_std) begin
				o_rd_data <= std_ram[rd_off[mk14_pkg::RAM_INDEX_BITS-1:0]];
			end else begin
				o_rd_data <= mk14_pkg::UNMAPPED_READ;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/mk14_pkg.sv
// MK14 address, data and offset types, memory regions, unmapped read value, sequencer states.

`default_nettype none

package mk14_pkg;

	typedef logic [15:0] mk14_addr_t;
	typedef logic [7:0] mk14_data_t;

	// Address bits 15 to 12 are not decoded.
	localparam int ADDR_DECODE_BITS = 12;

	typedef logic [ADDR_DECODE_BITS-1:0] mk14_offset_t;

	// ==============================
	// Memory regions
	// ==============================

	localparam int unsigned ROM_BASE = 'h000;
	localparam int unsigned ROM_SIZE = 512;
	localparam int unsigned EXT_RAM_BASE = 'hB00;
	localparam int unsigned EXT_RAM_SIZE = 256;
	localparam int unsigned STD_RAM_BASE = 'hF00;
	localparam int unsigned STD_RAM_SIZE = 256;

	// Both RAM regions are 256 bytes and size aligned.
	localparam int ROM_INDEX_BITS = $clog2(ROM_SIZE);
	localparam int RAM_INDEX_BITS = $clog2(EXT_RAM_SIZE);

	// Floating bus reads as all ones.
	localparam mk14_data_t UNMAPPED_READ = 8'hFF;

	// ==============================
	// Sequencer states
	// ==============================

	typedef enum logic [1:0] {
		S_RX_WAIT,
		S_START,
		S_RUNNING,
		S_ERROR
	} seq_state_t;

endpackage

`default_nettype wire

// File: dv/loader_patterns.txt
# Columns: command, then arguments. C record text; R address, byte (hex);
# E error code (decimal); S core enable, loading; X soft reset.
C :040F000012345678D9
C :021f0500abcd62
C :00000001FF
E 0
S 1 0
R 0F00 12
R 0F01 34
R 0F02 56
R 0F03 78
R 0F05 AB
R 1F06 CD
X
C :010F1000558C
C :00000001FF
E 2
S 0 0
X
C :01060000AA4F
E 4
R 0600 FF
X
C :010B00005A9A
R 0B00 5A
C :010B0002777B
E 3
R 0B00 5A
X
S 0 1
E 0
R 0F00 12
R 0F05 AB

// File: dv/mk14_loader_assertions.sv
// Bound assertions on core enable, write strobe length and loader state rules.

`default_nettype none
`timescale 1ns/1ps

module mk14_loader_assertions (
	input wire logic clk,
	input wire logic soft_reset,
	input wire logic char_valid,
	input wire logic wr_valid,
	input wire logic o_core_en,
	input wire logic o_loading,
	input wire ihex_pkg::ihex_error_t o_error
);

	// A started core never carries an error.
	core_en_clean: assert property (@(posedge clk) disable iff (soft_reset)
		o_core_en |-> o_error == ihex_pkg::ERR_NONE)
		else $error("core enabled with error code %0d", o_error);

	// Each write needs a fresh character.
	wr_single_cycle: assert property (@(posedge clk) disable iff (soft_reset)
		(wr_valid && !char_valid) |=> !wr_valid)
		else $error("write strobe held without a character");

	loading_vs_core_en: assert property (@(posedge clk) disable iff (soft_reset)
		!(o_loading && o_core_en))
		else $error("loading and core enable high together");

endmodule

bind mk14_loader mk14_loader_assertions i_mk14_loader_assertions (
	.clk,
	.soft_reset,
	.char_valid,
	.wr_valid,
	.o_core_en,
	.o_loading,
	.o_error
);

`default_nettype wire

// File: dv/mk14_loader_tb.sv
// MK14 loader testbench: clock, reset, pattern file stimulus, typed checks and timeout.

`default_nettype none
`timescale 1ns/1ps

module mk14_loader_tb;

	localparam int SETTLE_CYCLES = 4;
	localparam int MAX_GAP = 3;

	logic clk;
	logic soft_reset;
	logic i_rx_valid;
	ihex_pkg::ihex_byte_t i_rx_data;
	logic i_rd_en;
	mk14_pkg::mk14_addr_t i_rd_addr;
	mk14_pkg::mk14_data_t o_rd_data;
	logic o_core_en;
	logic o_loading;
	ihex_pkg::ihex_error_t o_error;
	ihex_pkg::record_count_t o_record_count;

	string cmd_q[$];
	string text_q[$];
	int arg_a_q[$];
	int arg_b_q[$];
	int cycle_count;
	int cycle_limit;

	// Records accepted since the last reset, and whether loading has stopped.
	ihex_pkg::record_count_t exp_count;
	logic exp_stopped;

	mk14_loader i_mk14_loader (
		.clk,
		.soft_reset,
		.i_rx_valid,
		.i_rx_data,
		.i_rd_en,
		.i_rd_addr,
		.o_rd_data,
		.o_core_en,
		.o_loading,
		.o_error,
		.o_record_count
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped");
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			abort_run($sformatf("timeout: the run took more than %0d cycles", cycle_limit));
		end
	end

	// ==============================
	// Typed compares
	// ==============================

	task automatic check_data(input string what, input mk14_pkg::mk14_data_t actual,
			input mk14_pkg::mk14_data_t expected);
		if (actual !== expected) begin
			abort_run($sformatf("error at %0d ns: %s is 0x%02h, expected 0x%02h",
				$time, what, actual, expected));
		end
	endtask

	task automatic check_error(input string what, input ihex_pkg::ihex_error_t actual,
			input ihex_pkg::ihex_error_t expected);
		if (actual !== expected) begin
			abort_run($sformatf("error at %0d ns: %s is %0d, expected %0d",
				$time, what, actual, expected));
		end
	endtask

	task automatic check_flag(input string what, input logic actual, input logic expected);
		if (actual !== expected) begin
			abort_run($sformatf("error at %0d ns: %s is %b, expected %b",
				$time, what, actual, expected));
		end
	endtask

	task automatic check_count(input string what, input ihex_pkg::record_count_t actual,
			input ihex_pkg::record_count_t expected);
		if (actual !== expected) begin
			abort_run($sformatf("error at %0d ns: %s is %0d, expected %0d",
				$time, what, actual, expected));
		end
	endtask

	// ==============================
	// Expected record count
	// ==============================

	// MK14 regions after dropping the upper address bits.
	function automatic logic addr_mapped(input mk14_pkg::mk14_addr_t addr);
		int unsigned off;
		off = addr % (1 << mk14_pkg::ADDR_DECODE_BITS);
		return (off < mk14_pkg::ROM_BASE + mk14_pkg::ROM_SIZE)
			|| (off >= mk14_pkg::EXT_RAM_BASE
				&& off < mk14_pkg::EXT_RAM_BASE + mk14_pkg::EXT_RAM_SIZE)
			|| (off >= mk14_pkg::STD_RAM_BASE
				&& off < mk14_pkg::STD_RAM_BASE + mk14_pkg::STD_RAM_SIZE);
	endfunction

	// Zero checksum, type 00 or 01, and every data byte in a mapped region.
	function automatic logic record_clean(input string text);
		int nbytes;
		int sum;
		int addr;
		int rtype;
		logic clean;
		nbytes = (text.len() - 1) / 2;
		sum = 0;
		for (int i = 0; i < nbytes; i++) begin
			sum += text.substr(1 + 2 * i, 2 + 2 * i).atohex();
		end
		addr = text.substr(3, 6).atohex();
		rtype = text.substr(7, 8).atohex();
		clean = (sum % 256 == 0) && (rtype == 0 || rtype == 1);
		if (rtype == 0) begin
			for (int i = 0; i < nbytes - 5; i++) begin
				if (!addr_mapped(16'(addr + i))) begin
					clean = 1'b0;
				end
			end
		end
		return clean;
	endfunction

	// ==============================
	// Stimulus
	// ==============================

	task automatic settle();
		repeat (SETTLE_CYCLES) @(negedge clk);
	endtask

	task automatic apply_reset();
		@(negedge clk);
		soft_reset = 1'b1;
		repeat (2) @(negedge clk);
		soft_reset = 1'b0;
	endtask

	// Characters back to back, then a short idle gap.
	task automatic send_record(input string text);
		int gap;
		for (int i = 0; i < text.len(); i++) begin
			@(negedge clk);
			i_rx_valid = 1'b1;
			i_rx_data = text[i];
		end
		@(negedge clk);
		i_rx_valid = 1'b0;
		gap = $urandom % (MAX_GAP + 1);
		repeat (gap) @(negedge clk);
	endtask

	task automatic read_byte(input mk14_pkg::mk14_addr_t addr);
		@(negedge clk);
		i_rd_en = 1'b1;
		i_rd_addr = addr;
		@(negedge clk);
		i_rd_en = 1'b0;
	endtask

	task automatic load_patterns(output int units);
		int fd;
		int a;
		int b;
		logic bad;
		string tok;
		string text;
		string rest;
		units = 0;
		fd = $fopen("dv/loader_patterns.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open the pattern file dv/loader_patterns.txt");
		end
		while ($fscanf(fd, "%s", tok) == 1) begin
			text = "";
			a = 0;
			b = 0;
			bad = 1'b0;
			if (tok == "#") begin
				void'($fgets(rest, fd));
			end else if (tok == "C") begin
				bad = $fscanf(fd, "%s", text) != 1;
			end else if (tok == "R") begin
				bad = $fscanf(fd, "%h %h", a, b) != 2;
			end else if (tok == "E") begin
				bad = $fscanf(fd, "%d", a) != 1;
			end else if (tok == "S") begin
				bad = $fscanf(fd, "%d %d", a, b) != 2;
			end else if (tok != "X") begin
				bad = 1'b1;
			end
			if (bad) begin
				abort_run($sformatf("pattern file has a malformed %s command", tok));
			end
			if (tok != "#") begin
				cmd_q.push_back(tok);
				text_q.push_back(text);
				arg_a_q.push_back(a);
				arg_b_q.push_back(b);
				units += 1;
			end
		end
		$fclose(fd);
	endtask

	task automatic run_command(input string cmd, input string text, input int a, input int b);
		if (cmd == "C") begin
			send_record(text);
			if (!exp_stopped) begin
				if (record_clean(text)) begin
					exp_count = exp_count + 16'd1;
					exp_stopped = text.substr(7, 8).atohex() == 1;
				end else begin
					exp_stopped = 1'b1;
				end
			end
		end else if (cmd == "R") begin
			settle();
			read_byte(16'(a));
			check_data($sformatf("read of 0x%04h", a), o_rd_data, 8'(b));
		end else if (cmd == "E") begin
			settle();
			check_error("error code", o_error, ihex_pkg::ihex_error_t'(3'(a)));
			check_count("record count", o_record_count, exp_count);
		end else if (cmd == "S") begin
			settle();
			check_flag("core enable", o_core_en, a != 0);
			check_flag("loading", o_loading, b != 0);
		end else begin
			apply_reset();
			exp_count = '0;
			exp_stopped = 1'b0;
		end
	endtask

	initial begin
		int units;
		soft_reset = 1'b1;
		i_rx_valid = 1'b0;
		i_rx_data = '0;
		i_rd_en = 1'b0;
		i_rd_addr = '0;
		cycle_count = 0;
		cycle_limit = 0;
		exp_count = '0;
		exp_stopped = 1'b0;
		void'($urandom(62330));
		load_patterns(units);
		cycle_limit = units * 10 + 100;
		repeat (2) @(negedge clk);
		soft_reset = 1'b0;
		foreach (cmd_q[i]) begin
			run_command(cmd_q[i], text_q[i], arg_a_q[i], arg_b_q[i]);
		end
		settle();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Builds the MK14 loader testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
	-f sources.f \
	--top-module mk14_loader_tb \
	-Mdir obj_dir; then
	echo "build failed"
	exit 1
fi

if ! ./obj_dir/Vmk14_loader_tb; then
	echo "simulation failed"
	exit 1
fi

exit 0

// File: sources.f
design/ihex_pkg.sv
design/mk14_pkg.sv
design/ihex_record_decoder.sv
design/mk14_memory_map.sv
design/load_sequencer.sv
design/mk14_loader.sv
dv/mk14_loader_assertions.sv
dv/mk14_loader_tb.sv
